// ==== hdl/packet_if.sv ====
// packet interface carrying one received frame from a uart receiver to the merger
`default_nettype none

interface packet_if
    import uart_link_pkg::*;
();

    // one clk_rx cycle per completed frame, no back-pressure
    logic                  valid;
    // payload bits 62:0, stable while valid is high
    logic [data_width-1:0] packet;
    // odd parity failed on this frame
    logic                  parity_error;
    // v2 start bit rejected, informational strobe
    logic                  runt;

    // receiver owns every signal
    modport rx_side (
        output valid,
        output packet,
        output parity_error,
        output runt
    );

    // merger only observes
    modport merge_side (
        input valid,
        input packet,
        input parity_error,
        input runt
    );

endinterface

`default_nettype wire

// ==== hdl/packet_merger.sv ====
// packet merger that joins two link streams, drops bad parity frames and counts them
`default_nettype none

module packet_merger
    import uart_link_pkg::*;
(
    input  logic                  clk_rx,
    input  logic                  reset_n,
    // receiver results, link 0 wins a collision
    packet_if.merge_side          link0,
    packet_if.merge_side          link1,
    // merged stream, one packet per pulse
    output logic                  out_valid,
    output logic [data_width-1:0] out_packet,
    output link_id_t              out_link,
    // saturating count of dropped packets
    output error_count_t          parity_error_count
);

    // per-link classification of this cycle
    logic good0;
    logic good1;
    logic bad0;
    logic bad1;

    // one-deep parking slot for link 1 on a collision
    logic                  held_valid;
    logic [data_width-1:0] held_packet;

    // packet picked for the output register
    logic                  sel_valid;
    logic [data_width-1:0] sel_packet;
    link_id_t              sel_link;
    logic                  take_held;
    logic                  park_link1;

    // error counter arithmetic, one spare bit catches the overflow
    logic [1:0]                     error_inc;
    logic [$bits(error_count_t):0] error_sum;

    ////////////////////////////////////////
    // input classification
    ////////////////////////////////////////

    // runt cycles carry no frame and are ignored
    assign good0 = link0.valid && !link0.runt && !link0.parity_error;
    assign good1 = link1.valid && !link1.runt && !link1.parity_error;
    assign bad0  = link0.valid && !link0.runt && link0.parity_error;
    assign bad1  = link1.valid && !link1.runt && link1.parity_error;

    // link 1 waits one cycle when both arrive together
    assign park_link1 = good0 && good1;

    ////////////////////////////////////////
    // output select
    ////////////////////////////////////////

    // priority is link 0, then link 1, then the parked packet
    always_comb begin
        sel_valid  = 1'b0;
        sel_packet = link0.packet;
        sel_link   = link_id_t'(0);
        take_held  = 1'b0;

        if (good0) begin
            sel_valid = 1'b1;
        end else if (good1) begin
            sel_valid  = 1'b1;
            sel_packet = link1.packet;
            sel_link   = link_id_t'(1);
        end else if (held_valid) begin
            sel_valid  = 1'b1;
            sel_packet = held_packet;
            sel_link   = link_id_t'(1);
            take_held  = 1'b1;
        end
    end

    ////////////////////////////////////////
    // collision slot
    ////////////////////////////////////////

    always_ff @(posedge clk_rx) begin
        if (!reset_n) begin
            held_valid <= 1'b0;
        end else if (park_link1) begin
            held_valid <= 1'b1;
        end else if (take_held) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_rx) begin
        if (park_link1) begin
            held_packet <= link1.packet;
        end
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge clk_rx) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sel_valid;
        end
    end

    // payload and tag only move with a new packet
    always_ff @(posedge clk_rx) begin
        if (sel_valid) begin
            out_packet <= sel_packet;
            out_link   <= sel_link;
        end
    end

    ////////////////////////////////////////
    // parity error counter
    ////////////////////////////////////////

    // both links can fail in the same cycle, so the step is 0, 1 or 2
    assign error_inc = {1'b0, bad0} + {1'b0, bad1};
    assign error_sum = {1'b0, parity_error_count}
                     + {{($bits(error_count_t) - 1){1'b0}}, error_inc};

    always_ff @(posedge clk_rx) begin
        if (!reset_n) begin
            parity_error_count <= '0;
        end else if (error_sum[$bits(error_count_t)]) begin
            // stick at full scale once it wraps
            parity_error_count <= '1;
        end else begin
            parity_error_count <= error_sum[$bits(error_count_t)-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_link_pkg.sv ====
// uart link package with packet geometry and shared types for the two-link readout
`default_nettype none

package uart_link_pkg;

    ////////////////////////////////////////
    // packet geometry
    ////////////////////////////////////////

    // payload bits carried between start and stop bit, sent lsb first
    localparam int packet_width = 64;

    // payload without the parity bit, this is what leaves the merger
    localparam int data_width = packet_width - 1;

    // odd parity over the whole packet lives in the top payload bit
    localparam int parity_bit = packet_width - 1;

    // one start bit, the payload, one stop bit
    // receiver position 0 is start, 1..64 payload, 65 stop
    localparam int frame_bits = packet_width + 2;

    ////////////////////////////////////////
    // shared types
    ////////////////////////////////////////

    // bit position inside a frame, wide enough for frame_bits
    typedef logic [7:0] bit_count_t;

    // which serial link a packet came from
    typedef logic link_id_t;

    // saturating count of packets dropped for bad parity
    typedef logic [15:0] error_count_t;

endpackage

`default_nettype wire

// ==== hdl/uart_link_top.sv ====
// two-link uart readout top with one receiver per link feeding a common merger
`default_nettype none

module uart_link_top
    import uart_link_pkg::*;
(
    // receive clock shared by both links and the merger
    input  logic                  clk_rx,
    input  logic                  reset_n,
    // selects one (high) or two (low) clocks per bit on both links
    input  logic                  v3_mode,
    // serial lines, idle high
    input  logic                  rx_in_0,
    input  logic                  rx_in_1,
    // merged packet stream
    output logic                  out_valid,
    output logic [data_width-1:0] out_packet,
    output link_id_t              out_link,
    output error_count_t          parity_error_count
);

    ////////////////////////////////////////
    // receiver to merger links
    ////////////////////////////////////////

    packet_if link0_pkt ();
    packet_if link1_pkt ();

    ////////////////////////////////////////
    // receivers
    ////////////////////////////////////////

    uart_rx rx_link0 (
        .clk_rx  (clk_rx),
        .reset_n (reset_n),
        .rx_in   (rx_in_0),
        .v3_mode (v3_mode),
        .rx_out  (link0_pkt)
    );

    uart_rx rx_link1 (
        .clk_rx  (clk_rx),
        .reset_n (reset_n),
        .rx_in   (rx_in_1),
        .v3_mode (v3_mode),
        .rx_out  (link1_pkt)
    );

    ////////////////////////////////////////
    // merger
    ////////////////////////////////////////

    // link 0 takes priority when both frames finish together
    packet_merger merger (
        .clk_rx             (clk_rx),
        .reset_n            (reset_n),
        .link0              (link0_pkt),
        .link1              (link1_pkt),
        .out_valid          (out_valid),
        .out_packet         (out_packet),
        .out_link           (out_link),
        .parity_error_count (parity_error_count)
    );

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
// uart receiver for one readout link with start detection, bit sampling and parity check
`default_nettype none

module uart_rx
    import uart_link_pkg::*;
(
    // receive clock, one or two clocks per bit depending on mode
    input  logic      clk_rx,
    input  logic      reset_n,
    // serial line, idles high, asynchronous to clk_rx
    input  logic      rx_in,
    // high selects one clock per bit, low selects two clocks per bit
    input  logic      v3_mode,
    packet_if.rx_side rx_out
);

    // two-flop synchronizer on the serial line
    logic rx_d1;
    logic rx_d2;

    // frame in progress
    logic rx_busy;
    // sample phase, only the high phase takes a bit
    logic rx_phase;
    // position within the frame, 0 is the start bit
    bit_count_t rx_cnt;
    // payload shift register, fills from the top so bit 0 ends at the bottom
    logic [packet_width-1:0] rx_reg;

    // decoded sample conditions
    logic sample_now;
    logic at_start;
    logic at_stop;
    logic runt_start;

    ////////////////////////////////////////
    // input synchronizer
    ////////////////////////////////////////

    // line resets to idle level so no false start comes out of reset
    always_ff @(posedge clk_rx) begin
        if (!reset_n) begin
            rx_d1 <= 1'b1;
            rx_d2 <= 1'b1;
        end else begin
            rx_d1 <= rx_in;
            rx_d2 <= rx_d1;
        end
    end

    ////////////////////////////////////////
    // sample decode
    ////////////////////////////////////////

    // a bit is taken on every clock in v3, every second clock in v2
    assign sample_now = rx_busy && rx_phase;

    // only v2 ever sits at position 0 while busy
    assign at_start = (rx_cnt == '0);

    // stop bit position ends the frame
    assign at_stop = (rx_cnt == bit_count_t'(frame_bits - 1));

    // start bit already gone high at its mid sample
    assign runt_start = !v3_mode && at_start && rx_d2;

    ////////////////////////////////////////
    // frame control
    ////////////////////////////////////////

    always_ff @(posedge clk_rx) begin
        if (!reset_n) begin
            rx_busy      <= 1'b0;
            rx_phase     <= 1'b0;
            rx_cnt       <= '0;
            rx_out.valid <= 1'b0;
            rx_out.runt  <= 1'b0;
        end else begin
            // both strobes last a single cycle
            rx_out.valid <= 1'b0;
            rx_out.runt  <= 1'b0;

            if (!rx_busy) begin
                // first low sample while idle opens a frame
                if (!rx_d2) begin
                    rx_busy  <= 1'b1;
                    rx_phase <= 1'b1;
                    // v3 is already past the start bit on the next sample,
                    // v2 still has to confirm it at mid bit
                    rx_cnt   <= v3_mode ? bit_count_t'(1) : '0;
                end
            end else begin
                // v3 samples every clock, v2 alternates
                rx_phase <= v3_mode ? 1'b1 : ~rx_phase;

                if (rx_phase) begin
                    if (runt_start) begin
                        // glitch, drop back to idle without a frame
                        rx_busy     <= 1'b0;
                        rx_out.runt <= 1'b1;
                    end else if (at_stop) begin
                        // stop position reached, hand the frame over
                        rx_busy      <= 1'b0;
                        rx_out.valid <= 1'b1;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // payload capture and parity
    ////////////////////////////////////////

    always_ff @(posedge clk_rx) begin
        // payload positions 1..64, lsb arrives first
        if (sample_now && !at_start && !at_stop) begin
            rx_reg <= {rx_d2, rx_reg[packet_width-1:1]};
        end

        // full packet is in rx_reg by the time the stop bit is sampled
        if (sample_now && at_stop) begin
            rx_out.packet <= rx_reg[parity_bit-1:0];
            // odd parity: the parity bit must be the inverse of the data xor
            rx_out.parity_error <= (rx_reg[parity_bit] == (^rx_reg[parity_bit-1:0]));
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the uart link testbench with Verilator, run it, and decide pass or fail
# from the simulation log.

top=tb_uart_link
obj_dir=obj_dir
sim_bin=sim_tb_uart_link
log=sim.log

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --top-module "$top" --Mdir "$obj_dir" -o "$sim_bin" -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$obj_dir/$sim_bin" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "Everything OK" "$log"; then
    if [ "$status" -ne 0 ]; then
        echo "RESULT: fail"
        exit 1
    fi
    echo "RESULT: pass"
    exit 0
else
    echo "RESULT: fail"
    exit 1
fi

// ==== src.f ====
+incdir+testbench
hdl/uart_link_pkg.sv
hdl/packet_if.sv
hdl/uart_rx.sv
hdl/packet_merger.sv
hdl/uart_link_top.sv
testbench/tb_uart_link.sv

// ==== testbench/tb_uart_link_vectors.svh ====
// stimulus and expected results for the uart link testbench with one row per step
`ifndef tb_uart_link_vectors_svh
`define tb_uart_link_vectors_svh

////////////////////////////////////////
// row layout
////////////////////////////////////////

typedef struct packed {
    // high for one clock per bit and low for two
    logic        v3;
    // links that send a frame in this row
    logic        send0;
    logic        send1;
    // flip the parity bit on that link
    logic        bad0;
    logic        bad1;
    // one-sample low pulse on link 0 ahead of the frame
    logic        runt;
    // packets expected on out_valid
    logic [1:0]  exp_count;
    // bit n holds the link of the n-th output packet
    logic [1:0]  exp_links;
    // parity_error_count after the row settles
    logic [15:0] exp_errors;
} vector_t;

localparam int num_vectors = 8;

////////////////////////////////////////
// table
////////////////////////////////////////

// v3, send0, send1, bad0, bad1, runt, count, links, errors
vector_t vectors [0:num_vectors-1] = '{
    // good packet on link 0 with one clock per bit
    '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd1, 2'b00, 16'd0},
    // good packet on link 1 with two clocks per bit
    '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd1, 2'b01, 16'd0},
    // inverted parity is dropped and counted
    '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0, 2'b00, 16'd1},
    // next good packet still passes
    '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd1, 2'b00, 16'd1},
    // both links together give link 0 first and link 1 after it
    '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2'd2, 2'b10, 16'd1},
    // runt start and then a full v2 frame on link 0
    '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 2'd1, 2'b00, 16'd1},
    // both corrupt in the same frame so the count steps by two
    '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd0, 2'b00, 16'd3},
    // collision again in v2
    '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2'd2, 2'b10, 16'd3}
};

`endif

// ==== testbench/tb_uart_link.sv ====
// table driven testbench for the two-link uart readout with lfsr payloads and parity checks
`default_nettype none

module tb_uart_link
    import uart_link_pkg::*;
();

    // test timing and limits
    localparam int          clk_period   = 40;
    localparam int          drive_delay  = 1;
    localparam int          wait_timeout = 300;
    localparam int          quiet_cycles = 160;
    localparam logic [31:0] lfsr_seed    = 32'h3833;

    // dut ports
    logic                  clk_rx;
    logic                  reset_n;
    logic                  v3_mode;
    logic                  rx_in_0;
    logic                  rx_in_1;
    logic                  out_valid;
    logic [data_width-1:0] out_packet;
    link_id_t              out_link;
    error_count_t          parity_error_count;

    // payload generator state
    logic [31:0] lfsr_state;
    // last frame sent on each link by link id
    logic [packet_width-1:0] sent_frame [0:1];
    // running count of out_valid pulses over the whole run
    int valid_pulses = 0;

    `include "tb_uart_link_vectors.svh"

    uart_link_top uart_link_top_inst (
        .clk_rx             (clk_rx),
        .reset_n            (reset_n),
        .v3_mode            (v3_mode),
        .rx_in_0            (rx_in_0),
        .rx_in_1            (rx_in_1),
        .out_valid          (out_valid),
        .out_packet         (out_packet),
        .out_link           (out_link),
        .parity_error_count (parity_error_count)
    );

    initial begin
        clk_rx = 1'b0;
        forever begin
            #(clk_period / 2) clk_rx = ~clk_rx;
        end
    end

    // the rising edge still sees the value of the cycle that just closed
    always @(posedge clk_rx) begin
        if (out_valid) begin
            valid_pulses++;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // one lfsr step per payload bit and odd parity on top
    task automatic build_frame(input logic corrupt, output logic [packet_width-1:0] frame);
        logic [data_width-1:0] data;
        for (int i = 0; i < data_width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            data[i] = lfsr_state[0];
        end
        // corrupt turns the odd count of ones into an even one
        frame = {(~(^data)) ^ corrupt, data};
    endtask

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, expected);
            stop_on_error("value mismatch");
        end
    endtask

    // both lines idle high and move just after the rising edge
    task automatic idle_cycles(input int count);
        for (int c = 0; c < count; c++) begin
            @(posedge clk_rx);
            #drive_delay;
            rx_in_0 = 1'b1;
            rx_in_1 = 1'b1;
        end
    endtask

    // start bit then 64 payload bits lsb first then the stop bit
    // a link that does not send stays idle
    task automatic send_frames(input logic use0, input logic use1,
                               input logic [packet_width-1:0] frame0,
                               input logic [packet_width-1:0] frame1);
        logic [frame_bits-1:0] line0;
        logic [frame_bits-1:0] line1;
        int                    clocks_per_bit;
        line0 = {1'b1, frame0, 1'b0};
        line1 = {1'b1, frame1, 1'b0};
        clocks_per_bit = v3_mode ? 1 : 2;
        for (int pos = 0; pos < frame_bits; pos++) begin
            for (int c = 0; c < clocks_per_bit; c++) begin
                @(posedge clk_rx);
                #drive_delay;
                rx_in_0 = use0 ? line0[pos] : 1'b1;
                rx_in_1 = use1 ? line1[pos] : 1'b1;
            end
        end
    endtask

    // single clock low on link 0 is shorter than a v2 bit
    task automatic send_runt();
        @(posedge clk_rx);
        #drive_delay;
        rx_in_0 = 1'b0;
        idle_cycles(1);
    endtask

    // outputs are sampled on the falling edge where they are stable
    task automatic wait_for_output();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_rx);
            cycles++;
        end while (!out_valid && cycles < wait_timeout);
        if (!out_valid) begin
            stop_on_error("timed out waiting for out_valid");
        end
    endtask

    task automatic expect_quiet();
        for (int c = 0; c < quiet_cycles; c++) begin
            @(negedge clk_rx);
            if (out_valid) begin
                stop_on_error("out_valid pulsed when no packet was expected");
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        vector_t vec;
        int      exp_link;
        int      pulses_at_row;

        reset_n       = 1'b0;
        v3_mode       = 1'b1;
        rx_in_0       = 1'b1;
        rx_in_1       = 1'b1;
        lfsr_state    = lfsr_seed;
        sent_frame[0] = '0;
        sent_frame[1] = '0;

        repeat (3) @(posedge clk_rx);
        #drive_delay;
        reset_n = 1'b1;

        @(negedge clk_rx);
        check_value("out_valid after reset", 64'(out_valid), 64'd0);
        check_value("parity_error_count after reset", 64'(parity_error_count), 64'd0);

        for (int row = 0; row < num_vectors; row++) begin
            vec = vectors[row];
            // mode only changes while both receivers idle
            @(posedge clk_rx);
            #drive_delay;
            v3_mode = vec.v3;
            pulses_at_row = valid_pulses;
            idle_cycles(4);

            if (vec.runt) begin
                send_runt();
                idle_cycles(6);
            end

            if (vec.send0) begin
                build_frame(vec.bad0, sent_frame[0]);
            end
            if (vec.send1) begin
                build_frame(vec.bad1, sent_frame[1]);
            end
            send_frames(vec.send0, vec.send1, sent_frame[0], sent_frame[1]);

            // outputs come in table order and carry the frame without parity
            for (int n = 0; n < int'(vec.exp_count); n++) begin
                wait_for_output();
                exp_link = int'(vec.exp_links[n]);
                check_value("out_link", 64'(out_link), 64'(exp_link));
                check_value("out_packet", 64'(out_packet),
                            64'(sent_frame[exp_link][data_width-1:0]));
            end

            expect_quiet();
            // catches pulses that came while the frame was still on the line
            check_value("out_valid pulses in row", 64'(valid_pulses - pulses_at_row),
                        64'(vec.exp_count));
            check_value("parity_error_count", 64'(parity_error_count), 64'(vec.exp_errors));
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
